// ==== design/encr_frame_reassembler.sv ====
// Top level of the encryption frame reassembler.
// Takes a valid-paced payload stream and rebuilds 510-word frames of
// four rows with frame overhead, encryption overhead and FEC columns.
// Output words come one clock after the framed input cycle.

`timescale 1ns/1ps

module encr_frame_reassembler
(
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  logic                                    i_valid,
    input  logic                                    i_sof,
    input  logic                                    i_resync,
    input  logic                                    i_payload_valid,
    input  logic [reassembler_pkg::NB_DATA-1:0]     i_payload_data,
    input  logic [reassembler_pkg::NB_FRAME_OH-1:0] i_frame_oh,
    input  logic [reassembler_pkg::NB_ENCR_OH-1:0]  i_encr_oh,
    output logic                                    o_valid,
    output logic                                    o_sof,
    output logic [reassembler_pkg::NB_DATA-1:0]     o_data,
    output logic                                    o_encr_oh_req,
    output logic [reassembler_pkg::NB_COUNTER-1:0]  o_overflow_count,
    output logic [reassembler_pkg::NB_COUNTER-1:0]  o_underflow_count
);

    logic                                frame_start;
    logic                                synced;
    logic                                pos_valid;
    logic                                payload_read;
    logic [reassembler_pkg::NB_DATA-1:0] payload_data;
    logic [reassembler_pkg::NB_BLOCK-1:0] row_oh;
    reassembler_pkg::frame_pos_t         pos;
    reassembler_pkg::frame_word_t        word;

    frame_sync u_frame_sync (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_sof         (i_sof),
        .i_resync      (i_resync),
        .o_frame_start (frame_start),
        .o_synced      (synced)
    );

    // fifo stays empty until aligned
    payload_fifo u_payload_fifo (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_flush           (~synced),
        .i_wr_valid        (i_payload_valid),
        .i_wr_data         (i_payload_data),
        .i_rd              (payload_read),
        .o_rd_data         (payload_data),
        .o_overflow_count  (o_overflow_count),
        .o_underflow_count (o_underflow_count)
    );

    frame_position u_frame_position (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_frame_start  (frame_start),
        .i_synced       (synced),
        .o_pos          (pos),
        .o_pos_valid    (pos_valid),
        .o_payload_read (payload_read)
    );

    encr_oh_capture u_encr_oh_capture (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_pos         (pos),
        .i_pos_valid   (pos_valid),
        .i_encr_oh     (i_encr_oh),
        .o_encr_oh_req (o_encr_oh_req),
        .o_row_oh      (row_oh)
    );

    frame_assembler u_frame_assembler (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_pos       (pos),
        .i_pos_valid (pos_valid),
        .i_frame_oh  (i_frame_oh),
        .i_row_oh    (row_oh),
        .i_payload   (payload_data),
        .o_word      (word)
    );

    assign o_valid = word.valid;
    assign o_sof   = word.sof;
    assign o_data  = word.data;

endmodule

// ==== design/encr_oh_capture.sv ====
// Encryption overhead request and capture.
// The request goes out at row 0, column 100 and the 256-bit overhead is
// loaded on the next framed cycle. Each row then takes its own 64-bit
// slice of the held value, row 0 from the top.

`timescale 1ns/1ps

module encr_oh_capture
(
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  reassembler_pkg::frame_pos_t             i_pos,
    input  logic                                    i_pos_valid,
    input  logic [reassembler_pkg::NB_ENCR_OH-1:0]  i_encr_oh,
    output logic                                    o_encr_oh_req,
    output logic [reassembler_pkg::NB_BLOCK-1:0]    o_row_oh
);

    logic                                   pending;
    logic [reassembler_pkg::NB_ENCR_OH-1:0] encr_oh_q;
    logic [reassembler_pkg::NB_ROW-1:0]     slice_idx;

    assign o_encr_oh_req = i_pos_valid
                         & (i_pos.row == '0)
                         & (i_pos.col == reassembler_pkg::ENCR_OH_REQ_COL);

    // capture waits for the next framed cycle
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            pending <= 1'b0;
        else if (i_pos_valid)
            pending <= o_encr_oh_req;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            encr_oh_q <= '0;
        else if (pending && i_pos_valid)
            encr_oh_q <= i_encr_oh;
    end

    // row 0 maps to the top slice
    assign slice_idx = reassembler_pkg::ROW_LAST - i_pos.row;
    assign o_row_oh  = encr_oh_q[slice_idx*reassembler_pkg::NB_BLOCK +: reassembler_pkg::NB_BLOCK];

endmodule

// ==== design/frame_assembler.sv ====
// Output word builder.
// On every framed cycle one word is registered, chosen by the column
// region: frame overhead in the upper half at column 0, the row's
// encryption overhead slice at column 119, zeros in the FEC columns and
// the FIFO head everywhere else. valid and sof line up with the data.

`timescale 1ns/1ps

module frame_assembler
(
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  reassembler_pkg::frame_pos_t             i_pos,
    input  logic                                    i_pos_valid,
    input  logic [reassembler_pkg::NB_FRAME_OH-1:0] i_frame_oh,
    input  logic [reassembler_pkg::NB_BLOCK-1:0]    i_row_oh,
    input  logic [reassembler_pkg::NB_DATA-1:0]     i_payload,
    output reassembler_pkg::frame_word_t            o_word
);

    localparam int NB_OH_PAD   = reassembler_pkg::NB_DATA - reassembler_pkg::NB_FRAME_OH;
    localparam int NB_ENCR_PAD = reassembler_pkg::NB_DATA - reassembler_pkg::NB_BLOCK;

    logic [reassembler_pkg::NB_DATA-1:0] next_data;
    logic                                is_start;
    logic                                valid_q;
    logic                                sof_q;
    logic [reassembler_pkg::NB_DATA-1:0] data_q;

    always_comb
    begin
        case (i_pos.region)
            reassembler_pkg::REGION_FRAME_OH:
                next_data = {i_frame_oh, {NB_OH_PAD{1'b0}}};
            reassembler_pkg::REGION_ENCR_OH:
                next_data = {{NB_ENCR_PAD{1'b0}}, i_row_oh};
            reassembler_pkg::REGION_PAYLOAD:
                next_data = i_payload;
            default:
                next_data = '0;
        endcase
    end

    assign is_start = (i_pos.row == '0) && (i_pos.col == '0);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_q <= 1'b0;
            sof_q   <= 1'b0;
        end
        else
        begin
            valid_q <= i_pos_valid;
            sof_q   <= i_pos_valid & is_start;
        end
    end

    // data holds between framed cycles
    always_ff @(posedge i_clock)
    begin
        if (i_pos_valid)
            data_q <= next_data;
    end

    assign o_word.valid = valid_q;
    assign o_word.sof   = sof_q;
    assign o_word.data  = data_q;

endmodule

// ==== design/frame_position.sv ====
// Row and column tracking for the reassembled frame.
// Rows alternate between 127 and 128 columns, starting short, over four
// rows. The position only moves on valid cycles once synced, and the
// frame_start cycle is forced to row 0, column 0. Also decodes the
// column region and strobes a payload read on payload columns.

`timescale 1ns/1ps

module frame_position
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_frame_start,
    input  logic                        i_synced,
    output reassembler_pkg::frame_pos_t o_pos,
    output logic                        o_pos_valid,
    output logic                        o_payload_read
);

    logic [reassembler_pkg::NB_ROW-1:0] row;
    logic [reassembler_pkg::NB_COL-1:0] col;
    logic                               long_row;
    logic [reassembler_pkg::NB_ROW-1:0] cur_row;
    logic [reassembler_pkg::NB_COL-1:0] cur_col;
    logic                               cur_long;
    logic [reassembler_pkg::NB_COL-1:0] col_last;
    logic                               row_end;
    reassembler_pkg::frame_region_e     region;

    assign o_pos_valid = i_valid & (i_synced | i_frame_start);

    // start cycle overrides the stored position
    assign cur_row  = i_frame_start ? '0 : row;
    assign cur_col  = i_frame_start ? '0 : col;
    assign cur_long = i_frame_start ? 1'b0 : long_row;

    assign col_last = cur_long ? reassembler_pkg::COL_LAST_LONG
                               : reassembler_pkg::COL_LAST_SHORT;
    assign row_end  = (cur_col == col_last);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            row      <= '0;
            col      <= '0;
            long_row <= 1'b0;
        end
        else if (o_pos_valid)
        begin
            if (row_end)
            begin
                col      <= '0;
                long_row <= ~cur_long;
                row      <= (cur_row == reassembler_pkg::ROW_LAST) ? '0 : cur_row + 1'b1;
            end
            else
            begin
                col      <= cur_col + 1'b1;
                long_row <= cur_long;
                row      <= cur_row;
            end
        end
    end

    always_comb
    begin
        if (cur_col == '0)
            region = reassembler_pkg::REGION_FRAME_OH;
        else if (cur_col == reassembler_pkg::ENCR_OH_COL)
            region = reassembler_pkg::REGION_ENCR_OH;
        else if (cur_col >= reassembler_pkg::FEC_COL)
            region = reassembler_pkg::REGION_FEC;
        else
            region = reassembler_pkg::REGION_PAYLOAD;
    end

    assign o_pos.row    = cur_row;
    assign o_pos.col    = cur_col;
    assign o_pos.region = region;

    assign o_payload_read = o_pos_valid & (region == reassembler_pkg::REGION_PAYLOAD);

    // short rows must wrap one column early
    a_col_limit : assert property (
        @(posedge i_clock) disable iff (i_reset)
        !long_row |-> (col <= reassembler_pkg::COL_LAST_SHORT)
    ) else $error("column past end of short row");

endmodule

// ==== design/frame_sync.sv ====
// Frame alignment for the reassembler.
// After reset or a resync the unit is armed and waits for the first
// valid start-of-frame. That cycle is flagged as frame_start and the
// synced flag is held until the next resync.

`timescale 1ns/1ps

module frame_sync
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_valid,
    input  logic i_sof,
    input  logic i_resync,
    output logic o_frame_start,
    output logic o_synced
);

    logic armed;
    logic synced;

    // first sof seen while waiting
    assign o_frame_start = armed & i_valid & i_sof;

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_resync)
        begin
            armed  <= 1'b1;
            synced <= 1'b0;
        end
        else if (o_frame_start)
        begin
            armed  <= 1'b0;
            synced <= 1'b1;
        end
    end

    assign o_synced = synced;

    // a new frame start is only taken while out of sync
    a_no_start_when_synced : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_synced |-> !o_frame_start
    ) else $error("frame_start while already synced");

endmodule

// ==== design/payload_fifo.sv ====
// Payload buffer between the input stream and the frame assembler.
// Sixteen words deep. A write is readable on the next clock and a read
// pops the head in the same cycle it is used. Reads from an empty FIFO
// return zero, writes into a full FIFO are dropped, and both events
// are counted in saturating counters. Flush empties the buffer.

`timescale 1ns/1ps

module payload_fifo
(
    input  logic                                      i_clock,
    input  logic                                      i_reset,
    input  logic                                      i_flush,
    input  logic                                      i_wr_valid,
    input  logic [reassembler_pkg::NB_DATA-1:0]       i_wr_data,
    input  logic                                      i_rd,
    output logic [reassembler_pkg::NB_DATA-1:0]       o_rd_data,
    output logic [reassembler_pkg::NB_COUNTER-1:0]    o_overflow_count,
    output logic [reassembler_pkg::NB_COUNTER-1:0]    o_underflow_count
);

    logic [reassembler_pkg::NB_DATA-1:0]      mem [reassembler_pkg::FIFO_DEPTH];
    logic [reassembler_pkg::NB_FIFO_ADDR-1:0] wr_ptr;
    logic [reassembler_pkg::NB_FIFO_ADDR-1:0] rd_ptr;
    logic [reassembler_pkg::NB_FIFO_ADDR:0]   level;
    logic                                     full;
    logic                                     empty;
    logic                                     wr_accept;
    logic                                     rd_accept;
    logic                                     overflow;
    logic                                     underflow;

    assign full  = (level == reassembler_pkg::FIFO_DEPTH);
    assign empty = (level == '0);

    assign wr_accept = i_wr_valid & ~full & ~i_flush;
    assign rd_accept = i_rd & ~empty & ~i_flush;
    assign overflow  = i_wr_valid & full & ~i_flush;
    assign underflow = i_rd & empty;

    // zero word when nothing is queued
    assign o_rd_data = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge i_clock)
    begin
        if (wr_accept)
            mem[wr_ptr] <= i_wr_data;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (wr_accept)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_accept)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_accept && !rd_accept)
                level <= level + 1'b1;
            else if (rd_accept && !wr_accept)
                level <= level - 1'b1;
        end
    end

    // counters stick at all ones
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_overflow_count  <= '0;
            o_underflow_count <= '0;
        end
        else
        begin
            if (overflow && (o_overflow_count != '1))
                o_overflow_count <= o_overflow_count + 1'b1;
            if (underflow && (o_underflow_count != '1))
                o_underflow_count <= o_underflow_count + 1'b1;
        end
    end

    a_level_bound : assert property (
        @(posedge i_clock) disable iff (i_reset)
        level <= reassembler_pkg::FIFO_DEPTH
    ) else $error("payload fifo level above depth");

endmodule

// ==== design/reassembler_pkg.sv ====
// Shared definitions for the encryption frame reassembler.
// Holds the frame geometry, the region encoding and the structs that
// carry a frame position and an output beat between the units.
// Modules refer to these by scoped names.

package reassembler_pkg;

    // word and overhead widths
    localparam int NB_DATA     = 256;
    localparam int NB_BLOCK    = 64;
    localparam int NB_FRAME_OH = 128;
    localparam int NB_ENCR_OH  = 256;

    // position counter widths
    localparam int NB_COL = 7;
    localparam int NB_ROW = 2;

    // error counter width
    localparam int NB_COUNTER = 16;

    // payload fifo geometry
    localparam int FIFO_DEPTH   = 16;
    localparam int NB_FIFO_ADDR = 4;

    // row layout, short rows first
    localparam logic [NB_COL-1:0] COL_LAST_SHORT = NB_COL'(126);
    localparam logic [NB_COL-1:0] COL_LAST_LONG  = NB_COL'(127);
    localparam logic [NB_ROW-1:0] ROW_LAST       = NB_ROW'(3);

    // special columns
    localparam logic [NB_COL-1:0] ENCR_OH_COL     = NB_COL'(119);
    localparam logic [NB_COL-1:0] ENCR_OH_REQ_COL = NB_COL'(100);
    localparam logic [NB_COL-1:0] FEC_COL         = NB_COL'(120);

    // what a column carries
    typedef enum logic [1:0] {
        REGION_FRAME_OH = 2'd0,
        REGION_PAYLOAD  = 2'd1,
        REGION_ENCR_OH  = 2'd2,
        REGION_FEC      = 2'd3
    } frame_region_e;

    // place of the current cycle in the frame
    typedef struct packed {
        logic [NB_ROW-1:0] row;
        logic [NB_COL-1:0] col;
        frame_region_e     region;
    } frame_pos_t;

    // one output beat
    typedef struct packed {
        logic               valid;
        logic               sof;
        logic [NB_DATA-1:0] data;
    } frame_word_t;

endpackage

// ==== filelist.f ====
design/reassembler_pkg.sv
design/frame_sync.sv
design/payload_fifo.sv
design/frame_position.sv
design/encr_oh_capture.sv
design/frame_assembler.sv
design/encr_frame_reassembler.sv
testbench/reassembler_checker.sv
testbench/tb_reassembler.sv

// ==== testbench/reassembler_checker.sv ====
// Reference model and scoreboard for the frame reassembler testbench.
// Samples DUT inputs and outputs on the falling clock edge, where both
// are settled, and steps a cycle model of the frame layout, the payload
// FIFO and the overhead capture. Each mismatch is printed when it is seen
// and counted per group for the closing summary in the testbench top.

`timescale 1ns/1ps

module reassembler_checker
(
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  logic                                    i_valid,
    input  logic                                    i_sof,
    input  logic                                    i_resync,
    input  logic                                    i_payload_valid,
    input  logic [reassembler_pkg::NB_DATA-1:0]     i_payload_data,
    input  logic [reassembler_pkg::NB_FRAME_OH-1:0] i_frame_oh,
    input  logic [reassembler_pkg::NB_ENCR_OH-1:0]  i_encr_oh,
    input  logic                                    i_dut_valid,
    input  logic                                    i_dut_sof,
    input  logic [reassembler_pkg::NB_DATA-1:0]     i_dut_data,
    input  logic                                    i_dut_encr_oh_req,
    input  logic [reassembler_pkg::NB_COUNTER-1:0]  i_dut_overflow_count,
    input  logic [reassembler_pkg::NB_COUNTER-1:0]  i_dut_underflow_count,
    output int                                      o_model_level,
    output int                                      o_sof_count,
    output int                                      o_ctrl_errors,
    output int                                      o_data_errors,
    output int                                      o_counter_errors
);

    logic [reassembler_pkg::NB_DATA-1:0]    fifo_q [$];
    logic [reassembler_pkg::NB_ENCR_OH-1:0] encr_oh;
    logic [reassembler_pkg::NB_DATA-1:0]    exp_data;
    logic [reassembler_pkg::NB_COUNTER-1:0] exp_overflow;
    logic [reassembler_pkg::NB_COUNTER-1:0] exp_underflow;
    logic                                   exp_valid;
    logic                                   exp_sof;
    logic                                   armed;
    logic                                   synced;
    logic                                   pending;
    logic                                   long_row;
    logic                                   have_expect;
    int                                     row;
    int                                     col;

    initial
    begin
        have_expect      = 1'b0;
        o_model_level    = 0;
        o_sof_count      = 0;
        o_ctrl_errors    = 0;
        o_data_errors    = 0;
        o_counter_errors = 0;
    end

    task automatic show_mismatch(string name, logic [255:0] expected, logic [255:0] actual);
        $display("Fail %s at %0t ns: expected 0x%0h, actual 0x%0h",
                 name, $time, expected, actual);
    endtask

    // registered outputs are the result of the previous model step
    task automatic compare_outputs();
        if (i_dut_valid !== exp_valid)
        begin
            show_mismatch("o_valid", exp_valid, i_dut_valid);
            o_ctrl_errors++;
        end
        if (i_dut_sof !== exp_sof)
        begin
            show_mismatch("o_sof", exp_sof, i_dut_sof);
            o_ctrl_errors++;
        end
        if (exp_valid && (i_dut_data !== exp_data))
        begin
            show_mismatch("o_data", exp_data, i_dut_data);
            o_data_errors++;
        end
        if (i_dut_overflow_count !== exp_overflow)
        begin
            show_mismatch("o_overflow_count", exp_overflow, i_dut_overflow_count);
            o_counter_errors++;
        end
        if (i_dut_underflow_count !== exp_underflow)
        begin
            show_mismatch("o_underflow_count", exp_underflow, i_dut_underflow_count);
            o_counter_errors++;
        end
        if (i_dut_sof === 1'b1)
            o_sof_count++;
    endtask

    task automatic step_model();
        logic                                start;
        logic                                pos_valid;
        logic                                full;
        logic                                req;
        logic                                lg;
        int                                  r;
        int                                  c;
        int                                  last_col;
        logic [reassembler_pkg::NB_DATA-1:0] word;
        if (i_reset)
        begin
            armed         = 1'b1;
            synced        = 1'b0;
            pending       = 1'b0;
            long_row      = 1'b0;
            row           = 0;
            col           = 0;
            encr_oh       = '0;
            exp_overflow  = '0;
            exp_underflow = '0;
            exp_valid     = 1'b0;
            exp_sof       = 1'b0;
            fifo_q.delete();
        end
        else
        begin
            start     = armed && i_valid && i_sof;
            pos_valid = i_valid && (synced || start);
            r         = start ? 0 : row;
            c         = start ? 0 : col;
            lg        = start ? 1'b0 : long_row;

            // request is combinational in the framed cycle itself
            req = pos_valid && (r == 0) && (c == reassembler_pkg::ENCR_OH_REQ_COL);
            if (i_dut_encr_oh_req !== req)
            begin
                show_mismatch("o_encr_oh_req", req, i_dut_encr_oh_req);
                o_ctrl_errors++;
            end

            full = (fifo_q.size() == reassembler_pkg::FIFO_DEPTH);
            word = '0;
            if (pos_valid)
            begin
                if (c == 0)
                    word[255:128] = i_frame_oh;
                else if (c == reassembler_pkg::ENCR_OH_COL)
                    word[63:0] = encr_oh[255 - 64*r -: 64];
                else if (c < reassembler_pkg::FEC_COL)
                begin
                    if (fifo_q.size() == 0)
                    begin
                        if (exp_underflow != '1)
                            exp_underflow = exp_underflow + 1'b1;
                    end
                    else
                        word = fifo_q.pop_front();
                end
            end

            // writes only land while aligned, otherwise the fifo is flushed
            if (synced)
            begin
                if (i_payload_valid && !full)
                    fifo_q.push_back(i_payload_data);
                else if (i_payload_valid && (exp_overflow != '1))
                    exp_overflow = exp_overflow + 1'b1;
            end
            else
                fifo_q.delete();

            if (pos_valid)
            begin
                if (pending)
                    encr_oh = i_encr_oh;
                pending  = req;
                last_col = lg ? 127 : 126;
                if (c == last_col)
                begin
                    col      = 0;
                    long_row = !lg;
                    row      = (r == 3) ? 0 : r + 1;
                end
                else
                begin
                    col      = c + 1;
                    long_row = lg;
                    row      = r;
                end
            end

            exp_valid = pos_valid;
            exp_sof   = pos_valid && (r == 0) && (c == 0);
            exp_data  = word;

            if (i_resync)
            begin
                armed  = 1'b1;
                synced = 1'b0;
            end
            else if (start)
            begin
                armed  = 1'b0;
                synced = 1'b1;
            end
        end
        o_model_level = fifo_q.size();
    endtask

    always @(negedge i_clock)
    begin
        if (have_expect)
            compare_outputs();
        step_model();
        have_expect = 1'b1;
    end

endmodule

// ==== testbench/tb_reassembler.sv ====
// Testbench for the encryption frame reassembler.
// Drives a seeded random stream through phases that sync, run whole
// frames, starve and flood the payload FIFO, then resync and restart.
// The checker module holds the reference model and counts mismatches;
// this module prints the closing summary and the result.

`timescale 1ns/1ps

module tb_reassembler;

    localparam int CLOCK_PERIOD    = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int FRAME_WORDS     = 510;
    localparam int PRE_SYNC_CYCLES = 20;
    localparam int RUN_CYCLES      = 1200;
    localparam int STARVE_CYCLES   = 40;
    localparam int SETTLE_CYCLES   = 100;
    localparam int FLOOD_CYCLES    = 60;
    localparam int GAP_CYCLES      = 30;
    localparam int FIXED_CYCLES    = PRE_SYNC_CYCLES + RUN_CYCLES + STARVE_CYCLES
                                   + 2*SETTLE_CYCLES + FLOOD_CYCLES + GAP_CYCLES;
    // margin covers the restart frame and the gaps in i_valid
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + FIXED_CYCLES + 3*FRAME_WORDS + 1000;
    localparam int HIGH_MARK       = 12;

    // payload write modes
    localparam int WRITE_THROTTLED = 0;
    localparam int WRITE_NONE      = 1;
    localparam int WRITE_ALL       = 2;

    integer seed = 79;
    int     restart_count;
    int     model_level;
    int     sof_count;
    int     ctrl_errors;
    int     data_errors;
    int     counter_errors;

    logic                                    clock;
    logic                                    reset;
    logic                                    valid;
    logic                                    sof;
    logic                                    resync;
    logic                                    payload_valid;
    logic [reassembler_pkg::NB_DATA-1:0]     payload_data;
    logic [reassembler_pkg::NB_FRAME_OH-1:0] frame_oh;
    logic [reassembler_pkg::NB_ENCR_OH-1:0]  encr_oh;
    logic                                    out_valid;
    logic                                    out_sof;
    logic [reassembler_pkg::NB_DATA-1:0]     out_data;
    logic                                    encr_oh_req;
    logic [reassembler_pkg::NB_COUNTER-1:0]  overflow_count;
    logic [reassembler_pkg::NB_COUNTER-1:0]  underflow_count;

    encr_frame_reassembler uut (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_valid           (valid),
        .i_sof             (sof),
        .i_resync          (resync),
        .i_payload_valid   (payload_valid),
        .i_payload_data    (payload_data),
        .i_frame_oh        (frame_oh),
        .i_encr_oh         (encr_oh),
        .o_valid           (out_valid),
        .o_sof             (out_sof),
        .o_data            (out_data),
        .o_encr_oh_req     (encr_oh_req),
        .o_overflow_count  (overflow_count),
        .o_underflow_count (underflow_count)
    );

    reassembler_checker u_checker (
        .i_clock               (clock),
        .i_reset               (reset),
        .i_valid               (valid),
        .i_sof                 (sof),
        .i_resync              (resync),
        .i_payload_valid       (payload_valid),
        .i_payload_data        (payload_data),
        .i_frame_oh            (frame_oh),
        .i_encr_oh             (encr_oh),
        .i_dut_valid           (out_valid),
        .i_dut_sof             (out_sof),
        .i_dut_data            (out_data),
        .i_dut_encr_oh_req     (encr_oh_req),
        .i_dut_overflow_count  (overflow_count),
        .i_dut_underflow_count (underflow_count),
        .o_model_level         (model_level),
        .o_sof_count           (sof_count),
        .o_ctrl_errors         (ctrl_errors),
        .o_data_errors         (data_errors),
        .o_counter_errors      (counter_errors)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD/2) clock = ~clock;
    end

    function automatic logic [reassembler_pkg::NB_DATA-1:0] random_bits();
        logic [reassembler_pkg::NB_DATA-1:0] value;
        for (int i = 0; i < 8; i++)
            value[i*32 +: 32] = $random(seed);
        return value;
    endfunction

    function automatic bit roll_percent(int pct);
        int draw;
        draw = $unsigned($random(seed)) % 100;
        return draw < pct;
    endfunction

    // one stimulus beat, 2 ns after the rising edge
    task automatic drive_cycle(int valid_pct, int write_mode, bit allow_sof);
        logic [reassembler_pkg::NB_DATA-1:0] oh_bits;
        @(posedge clock);
        #2;
        valid  = roll_percent(valid_pct);
        sof    = allow_sof && roll_percent(1);
        resync = 1'b0;
        case (write_mode)
            WRITE_THROTTLED: payload_valid = (model_level < HIGH_MARK);
            WRITE_NONE:      payload_valid = 1'b0;
            default:         payload_valid = 1'b1;
        endcase
        payload_data = random_bits();
        oh_bits      = random_bits();
        frame_oh     = oh_bits[reassembler_pkg::NB_FRAME_OH-1:0];
        encr_oh      = random_bits();
    endtask

    task automatic run_phase(int cycles, int valid_pct, int write_mode, bit allow_sof);
        repeat (cycles)
            drive_cycle(valid_pct, write_mode, allow_sof);
    endtask

    task automatic start_frame();
        // a sof without valid must not align the frame
        drive_cycle(0, WRITE_THROTTLED, 1'b0);
        sof = 1'b1;
        drive_cycle(100, WRITE_THROTTLED, 1'b0);
        sof = 1'b1;
    endtask

    task automatic pulse_resync();
        drive_cycle(0, WRITE_THROTTLED, 1'b0);
        resync = 1'b1;
    endtask

    task automatic print_counts(int other_errors);
        $display("errors: control %0d, data %0d, counter %0d, other %0d",
                 ctrl_errors, data_errors, counter_errors, other_errors);
    endtask

    task automatic finish_run();
        int other_errors;
        other_errors = 0;
        if (overflow_count == '0)
        begin
            $display("flood phase never dropped a payload write");
            other_errors++;
        end
        if (underflow_count == '0)
        begin
            $display("starve phase never read from an empty payload fifo");
            other_errors++;
        end
        print_counts(other_errors);
        if (ctrl_errors + data_errors + counter_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    initial
    begin
        reset         = 1'b1;
        valid         = 1'b0;
        sof           = 1'b0;
        resync        = 1'b0;
        payload_valid = 1'b0;
        payload_data  = '0;
        frame_oh      = '0;
        encr_oh       = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;

        // no output and no buffered payload before the first sof
        run_phase(PRE_SYNC_CYCLES, 90, WRITE_THROTTLED, 1'b0);
        start_frame();
        run_phase(RUN_CYCLES, 90, WRITE_THROTTLED, 1'b1);
        run_phase(STARVE_CYCLES, 90, WRITE_NONE, 1'b1);
        run_phase(SETTLE_CYCLES, 90, WRITE_THROTTLED, 1'b1);
        run_phase(FLOOD_CYCLES, 30, WRITE_ALL, 1'b1);
        run_phase(SETTLE_CYCLES, 90, WRITE_THROTTLED, 1'b1);

        pulse_resync();
        run_phase(GAP_CYCLES, 90, WRITE_THROTTLED, 1'b0);
        restart_count = sof_count;
        start_frame();
        // run one whole frame after the restart until the next sof
        while (sof_count < restart_count + 2)
            drive_cycle(90, WRITE_THROTTLED, 1'b1);
        run_phase(4, 0, WRITE_NONE, 1'b0);
        finish_run();
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired before the run completed");
        print_counts(1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
